// ==== Bender.yml ====
package:
  name: target_xbar

sources:
  - common/target_xbar_pkg.sv
  - target_xbar/target_addr_decode.sv
  - target_xbar/target_write_route.sv
  - target_xbar/target_read_route.sv
  - target_xbar/target_xbar_top.sv
  - target: test
    files:
      - verification/target_reg_model.sv
      - verification/target_xbar_tb.sv

// ==== target_xbar_top.f ====
common/target_xbar_pkg.sv
target_xbar/target_addr_decode.sv
target_xbar/target_write_route.sv
target_xbar/target_read_route.sv
target_xbar/target_xbar_top.sv
verification/target_reg_model.sv
verification/target_xbar_tb.sv

// ==== verification/target_xbar_tb.sv ====
`timescale 1ns/1ps

module target_xbar_tb;
	import target_xbar_pkg::*;

	localparam logic [31:0] LCG_SEED = 32'h81bf_6a9a;
	localparam logic [31:0] LCG_MUL  = 32'd1664525;
	localparam logic [31:0] LCG_INC  = 32'd1013904223;
	localparam int MODEL_DEPTH = 16;
	// Six + three + two + eight + nine transactions
	localparam int NUM_TXN     = 28;
	localparam int TIMEOUT_CYC = 20 * NUM_TXN;

	logic core_clk, ext_rst;
	logic s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
	addr_t s_awaddr_i, s_araddr_i;
	data_t s_wdata_i;
	strb_t s_wstrb_i;
	logic s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
	resp_t s_bresp_o, s_rresp_o;
	data_t s_rdata_o;
	logic [NUM_TARGETS-1:0] m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
	logic [NUM_TARGETS-1:0] m_arvalid, m_arready, m_rvalid, m_rready;
	addr_t m_awaddr, m_araddr;
	data_t m_wdata;
	strb_t m_wstrb;
	resp_t [NUM_TARGETS-1:0] m_bresp, m_rresp;
	data_t [NUM_TARGETS-1:0] m_rdata;

	logic [31:0] rng;
	data_t sb [addr_t];
	int errors, tests_run, tests_failed, cycles;
	logic miss_active;

	target_xbar_top UUT (
		.core_clk(core_clk), .ext_rst(ext_rst),
		.s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o), .s_awaddr_i(s_awaddr_i),
		.s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o), .s_wdata_i(s_wdata_i),
		.s_wstrb_i(s_wstrb_i), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
		.s_bresp_o(s_bresp_o), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
		.s_araddr_i(s_araddr_i), .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
		.s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o),
		.m_awvalid_o(m_awvalid), .m_awready_i(m_awready), .m_awaddr_o(m_awaddr),
		.m_wvalid_o(m_wvalid), .m_wready_i(m_wready), .m_wdata_o(m_wdata),
		.m_wstrb_o(m_wstrb), .m_bvalid_i(m_bvalid), .m_bready_o(m_bready),
		.m_bresp_i(m_bresp), .m_arvalid_o(m_arvalid), .m_arready_i(m_arready),
		.m_araddr_o(m_araddr), .m_rvalid_i(m_rvalid), .m_rready_o(m_rready),
		.m_rdata_i(m_rdata), .m_rresp_i(m_rresp)
	);

	for (genvar g = 0; g < NUM_TARGETS; g++) begin : g_model
		target_reg_model #(
			.SEED    (LCG_SEED ^ (g + 1)),
			.LCG_MUL (LCG_MUL),
			.LCG_INC (LCG_INC),
			.DEPTH   (MODEL_DEPTH)
		) u_model (
			.core_clk(core_clk), .ext_rst(ext_rst),
			.awvalid_i(m_awvalid[g]), .awready_o(m_awready[g]), .awaddr_i(m_awaddr),
			.wvalid_i(m_wvalid[g]), .wready_o(m_wready[g]), .wdata_i(m_wdata),
			.wstrb_i(m_wstrb), .bvalid_o(m_bvalid[g]), .bready_i(m_bready[g]),
			.bresp_o(m_bresp[g]), .arvalid_i(m_arvalid[g]), .arready_o(m_arready[g]),
			.araddr_i(m_araddr), .rvalid_o(m_rvalid[g]), .rready_i(m_rready[g]),
			.rdata_o(m_rdata[g]), .rresp_o(m_rresp[g])
		);
	end

	initial begin
		core_clk = 1'b0;
		forever #5 core_clk = ~core_clk;
	end

	always @(posedge core_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	a_b_hold: assert property (@(posedge core_clk) disable iff (ext_rst)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
		else begin
			errors++;
			$display("[FAIL] %0t s_bvalid_o/s_bresp_o held 1/%h now %b/%h", $time,
				$past(s_bresp_o), s_bvalid_o, s_bresp_o);
		end
	a_r_hold: assert property (@(posedge core_clk) disable iff (ext_rst)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
		else begin
			errors++;
			$display("[FAIL] %0t s_rvalid_o/s_rdata_o/s_rresp_o held 1/%h/%h now %b/%h/%h",
				$time, $past(s_rdata_o), $past(s_rresp_o), s_rvalid_o, s_rdata_o, s_rresp_o);
		end
	a_no_aw_in_b: assert property (@(posedge core_clk) disable iff (ext_rst)
		s_bvalid_o |-> !s_awready_o && !s_wready_o)
		else begin
			errors++;
			$display("Write beat accepted at %0t while a write response was pending", $time);
		end
	a_no_ar_in_r: assert property (@(posedge core_clk) disable iff (ext_rst)
		s_rvalid_o |-> !s_arready_o)
		else begin
			errors++;
			$display("Read address accepted at %0t while read data was pending", $time);
		end
	a_miss_quiet: assert property (@(posedge core_clk) disable iff (ext_rst)
		miss_active |-> (m_awvalid | m_wvalid | m_arvalid) == '0)
		else begin
			errors++;
			$display("[FAIL] %0t subordinate valids got %h expected 0", $time,
				m_awvalid | m_wvalid | m_arvalid);
		end
	a_decerr_zero: assert property (@(posedge core_clk) disable iff (ext_rst)
		s_rvalid_o && s_rresp_o == RESP_DECERR |-> s_rdata_o == '0)
		else begin
			errors++;
			$display("[FAIL] %0t s_rdata_o got %h expected 0", $time, s_rdata_o);
		end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * LCG_MUL + LCG_INC;
	endfunction

	function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
		data_t r;
		r = old;
		for (int b = 0; b < STRB_W; b++) begin
			if (s[b]) begin
				r[8*b +: 8] = nw[8*b +: 8];
			end
		end
		return r;
	endfunction

	function automatic data_t expected_word(input addr_t a);
		return sb.exists(a) ? sb[a] : '0;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic do_write(input addr_t a, input data_t d, input strb_t s, input int hold,
		output resp_t r);
		logic aw_go, w_go;
		@(negedge core_clk);
		s_awvalid_i = 1'b1;
		s_awaddr_i  = a;
		s_wvalid_i  = 1'b1;
		s_wdata_i   = d;
		s_wstrb_i   = s;
		while (s_awvalid_i || s_wvalid_i) begin
			aw_go = s_awvalid_i && s_awready_o;
			w_go  = s_wvalid_i && s_wready_o;
			@(negedge core_clk);
			if (aw_go) s_awvalid_i = 1'b0;
			if (w_go) s_wvalid_i = 1'b0;
		end
		while (!s_bvalid_o) @(negedge core_clk);
		// Response back-pressure
		repeat (hold) @(negedge core_clk);
		r = s_bresp_o;
		s_bready_i = 1'b1;
		@(negedge core_clk);
		s_bready_i = 1'b0;
	endtask

	task automatic do_read(input addr_t a, input int hold, output data_t d, output resp_t r);
		@(negedge core_clk);
		s_arvalid_i = 1'b1;
		s_araddr_i  = a;
		while (!s_arready_o) @(negedge core_clk);
		@(negedge core_clk);
		s_arvalid_i = 1'b0;
		while (!s_rvalid_o) @(negedge core_clk);
		repeat (hold) @(negedge core_clk);
		d = s_rdata_o;
		r = s_rresp_o;
		s_rready_i = 1'b1;
		@(negedge core_clk);
		s_rready_i = 1'b0;
	endtask

	task automatic write_checked(input addr_t a, input data_t d, input strb_t s, input int hold);
		resp_t r;
		do_write(a, d, s, hold, r);
		compare_value("s_bresp_o", r, RESP_OKAY);
		sb[a] = merge_bytes(expected_word(a), d, s);
	endtask

	task automatic read_checked(input addr_t a, input int hold);
		data_t d;
		resp_t r;
		do_read(a, hold, d, r);
		compare_value("s_rresp_o", r, RESP_OKAY);
		compare_value("s_rdata_o", d, expected_word(a));
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err_before);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	// Same word offset in every window, so a misrouted beat lands on another window's word
	addr_t win_addr [3] = '{32'h0000_0010, 32'h0002_0010, 32'h0002_1010};
	addr_t bp_addr [4]  = '{32'h0000_0000, 32'h0002_0004, 32'h0002_1000, 32'h0001_fffc};
	addr_t cw_addr [3]  = '{32'h0000_0020, 32'h0002_1014, 32'h0002_0038};

	initial begin
		int e;
		data_t d;
		resp_t r;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		miss_active = 1'b0;
		rng = LCG_SEED;
		ext_rst = 1'b1;
		{s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i} = '0;
		s_awaddr_i = '0;
		s_araddr_i = '0;
		s_wdata_i  = '0;
		s_wstrb_i  = '0;
		repeat (5) @(negedge core_clk);
		ext_rst = 1'b0;

		e = errors;
		@(negedge core_clk);
		compare_value("s_bvalid_o", s_bvalid_o, 1'b0);
		compare_value("s_rvalid_o", s_rvalid_o, 1'b0);
		compare_value("m_valids", m_awvalid | m_wvalid | m_arvalid, '0);
		compare_value("m_readies", m_bready | m_rready, '0);
		compare_value("s_readies", {s_awready_o, s_wready_o, s_arready_o}, 3'b111);
		finish_test("reset", e);

		e = errors;
		for (int i = 0; i < NUM_TARGETS; i++) begin
			rng = lcg_next(rng);
			write_checked(win_addr[i], rng, 4'hf, 0);
		end
		for (int i = 0; i < NUM_TARGETS; i++) begin
			read_checked(win_addr[i], 0);
		end
		finish_test("write_read_windows", e);

		e = errors;
		write_checked(32'h0002_0030, 32'h1122_3344, 4'hf, 0);
		write_checked(32'h0002_0030, 32'haabb_ccdd, 4'b1010, 0);
		read_checked(32'h0002_0030, 0);
		finish_test("partial_strobe", e);

		e = errors;
		miss_active = 1'b1;
		do_write(32'h0003_0000, 32'hdead_beef, 4'hf, 0, r);
		compare_value("s_bresp_o", r, RESP_DECERR);
		do_read(32'h0003_0000, 0, d, r);
		compare_value("s_rresp_o", r, RESP_DECERR);
		compare_value("s_rdata_o", d, '0);
		miss_active = 1'b0;
		finish_test("decode_error", e);

		e = errors;
		for (int i = 0; i < 4; i++) begin
			rng = lcg_next(rng);
			d = rng;
			rng = lcg_next(rng);
			write_checked(bp_addr[i], d, 4'hf, rng[18:16]);
		end
		for (int i = 0; i < 4; i++) begin
			rng = lcg_next(rng);
			read_checked(bp_addr[i], rng[18:16]);
		end
		finish_test("back_pressure", e);

		e = errors;
		for (int i = 0; i < NUM_TARGETS; i++) begin
			rng = lcg_next(rng);
			fork
				write_checked(cw_addr[i], rng, 4'hf, 1);
				read_checked(win_addr[(i + 1) % NUM_TARGETS], 1);
			join
		end
		for (int i = 0; i < NUM_TARGETS; i++) begin
			read_checked(cw_addr[i], 0);
		end
		finish_test("concurrent", e);

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/target_reg_model.sv ====
`timescale 1ns/1ps

module target_reg_model #(
	parameter logic [31:0] SEED    = 32'h1,
	parameter logic [31:0] LCG_MUL = 32'd1664525,
	parameter logic [31:0] LCG_INC = 32'd1013904223,
	parameter int          DEPTH   = 16
) (
	input  logic                      core_clk,
	input  logic                      ext_rst,
	input  logic                      awvalid_i,
	output logic                      awready_o,
	input  target_xbar_pkg::addr_t    awaddr_i,
	input  logic                      wvalid_i,
	output logic                      wready_o,
	input  target_xbar_pkg::data_t    wdata_i,
	input  target_xbar_pkg::strb_t    wstrb_i,
	output logic                      bvalid_o,
	input  logic                      bready_i,
	output target_xbar_pkg::resp_t    bresp_o,
	input  logic                      arvalid_i,
	output logic                      arready_o,
	input  target_xbar_pkg::addr_t    araddr_i,
	output logic                      rvalid_o,
	input  logic                      rready_i,
	output target_xbar_pkg::data_t    rdata_o,
	output target_xbar_pkg::resp_t    rresp_o
);
	import target_xbar_pkg::*;

	data_t       mem [DEPTH];
	logic        aw_have, w_have, b_pend, ar_have, r_pend;
	addr_t       aw_addr, ar_addr;
	data_t       w_data;
	strb_t       w_strb;
	logic [31:0] rng;

	assign bresp_o = RESP_OKAY;
	assign rresp_o = RESP_OKAY;

	// Handshakes complete on the rising edge
	always @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			aw_have = 1'b0;
			w_have  = 1'b0;
			b_pend  = 1'b0;
			ar_have = 1'b0;
			r_pend  = 1'b0;
			rdata_o = '0;
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] = '0;
			end
		end else begin
			if (awvalid_i && awready_o) begin
				aw_have = 1'b1;
				aw_addr = awaddr_i;
			end
			if (wvalid_i && wready_o) begin
				w_have = 1'b1;
				w_data = wdata_i;
				w_strb = wstrb_i;
			end
			if (bvalid_o && bready_i) begin
				b_pend = 1'b0;
			end
			// Byte-lane merge once both beats are in
			if (aw_have && w_have && !b_pend) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (w_strb[b]) begin
						mem[aw_addr[2 +: $clog2(DEPTH)]][8*b +: 8] = w_data[8*b +: 8];
					end
				end
				aw_have = 1'b0;
				w_have  = 1'b0;
				b_pend  = 1'b1;
			end
			if (arvalid_i && arready_o) begin
				ar_have = 1'b1;
				ar_addr = araddr_i;
			end
			if (rvalid_o && rready_i) begin
				r_pend = 1'b0;
			end
			if (ar_have && !r_pend) begin
				rdata_o = mem[ar_addr[2 +: $clog2(DEPTH)]];
				r_pend  = 1'b1;
				ar_have = 1'b0;
			end
		end
	end

	// Random ready and valid timing, updated on the falling edge
	always @(negedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rng       = SEED;
			awready_o = 1'b0;
			wready_o  = 1'b0;
			bvalid_o  = 1'b0;
			arready_o = 1'b0;
			rvalid_o  = 1'b0;
		end else begin
			rng       = rng * LCG_MUL + LCG_INC;
			awready_o = !aw_have && !b_pend && rng[16];
			wready_o  = !w_have && !b_pend && rng[17];
			bvalid_o  = b_pend && (bvalid_o || rng[18]);
			arready_o = !ar_have && !r_pend && rng[19];
			rvalid_o  = r_pend && (rvalid_o || rng[20]);
		end
	end

endmodule

// ==== target_xbar/target_xbar_top.sv ====
`timescale 1ns/1ps

module target_xbar_top (
	input  logic                                              core_clk,
	input  logic                                              ext_rst,
	input  logic                                              s_awvalid_i,
	output logic                                              s_awready_o,
	input  target_xbar_pkg::addr_t                            s_awaddr_i,
	input  logic                                              s_wvalid_i,
	output logic                                              s_wready_o,
	input  target_xbar_pkg::data_t                            s_wdata_i,
	input  target_xbar_pkg::strb_t                            s_wstrb_i,
	output logic                                              s_bvalid_o,
	input  logic                                              s_bready_i,
	output target_xbar_pkg::resp_t                            s_bresp_o,
	input  logic                                              s_arvalid_i,
	output logic                                              s_arready_o,
	input  target_xbar_pkg::addr_t                            s_araddr_i,
	output logic                                              s_rvalid_o,
	input  logic                                              s_rready_i,
	output target_xbar_pkg::data_t                            s_rdata_o,
	output target_xbar_pkg::resp_t                            s_rresp_o,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_awvalid_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_awready_i,
	output target_xbar_pkg::addr_t                            m_awaddr_o,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_wvalid_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_wready_i,
	output target_xbar_pkg::data_t                            m_wdata_o,
	output target_xbar_pkg::strb_t                            m_wstrb_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_bvalid_i,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_bready_o,
	input  target_xbar_pkg::resp_t [target_xbar_pkg::NUM_TARGETS-1:0] m_bresp_i,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_arvalid_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_arready_i,
	output target_xbar_pkg::addr_t                            m_araddr_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_rvalid_i,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_rready_o,
	input  target_xbar_pkg::data_t [target_xbar_pkg::NUM_TARGETS-1:0] m_rdata_i,
	input  target_xbar_pkg::resp_t [target_xbar_pkg::NUM_TARGETS-1:0] m_rresp_i
);
	import target_xbar_pkg::*;

	addr_t    wr_dec_addr;
	tgt_sel_t wr_dec_sel;
	logic     wr_dec_hit;
	addr_t    rd_dec_addr;
	tgt_sel_t rd_dec_sel;
	logic     rd_dec_hit;

	// Write direction
	target_write_route u_write_route (
		.core_clk    (core_clk),
		.ext_rst     (ext_rst),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_awaddr_i  (s_awaddr_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_bresp_o   (s_bresp_o),
		.m_awvalid_o (m_awvalid_o),
		.m_awready_i (m_awready_i),
		.m_awaddr_o  (m_awaddr_o),
		.m_wvalid_o  (m_wvalid_o),
		.m_wready_i  (m_wready_i),
		.m_wdata_o   (m_wdata_o),
		.m_wstrb_o   (m_wstrb_o),
		.m_bvalid_i  (m_bvalid_i),
		.m_bready_o  (m_bready_o),
		.m_bresp_i   (m_bresp_i),
		.dec_addr_o  (wr_dec_addr),
		.dec_sel_i   (wr_dec_sel),
		.dec_hit_i   (wr_dec_hit)
	);

	target_addr_decode u_wr_decode (
		.addr_i (wr_dec_addr),
		.sel_o  (wr_dec_sel),
		.hit_o  (wr_dec_hit)
	);

	// Read direction
	target_read_route u_read_route (
		.core_clk    (core_clk),
		.ext_rst     (ext_rst),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_araddr_i  (s_araddr_i),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.m_arvalid_o (m_arvalid_o),
		.m_arready_i (m_arready_i),
		.m_araddr_o  (m_araddr_o),
		.m_rvalid_i  (m_rvalid_i),
		.m_rready_o  (m_rready_o),
		.m_rdata_i   (m_rdata_i),
		.m_rresp_i   (m_rresp_i),
		.dec_addr_o  (rd_dec_addr),
		.dec_sel_i   (rd_dec_sel),
		.dec_hit_i   (rd_dec_hit)
	);

	target_addr_decode u_rd_decode (
		.addr_i (rd_dec_addr),
		.sel_o  (rd_dec_sel),
		.hit_o  (rd_dec_hit)
	);

endmodule

// ==== target_xbar/target_read_route.sv ====
`timescale 1ns/1ps

module target_read_route (
	input  logic                                              core_clk,
	input  logic                                              ext_rst,
	input  logic                                              s_arvalid_i,
	output logic                                              s_arready_o,
	input  target_xbar_pkg::addr_t                            s_araddr_i,
	output logic                                              s_rvalid_o,
	input  logic                                              s_rready_i,
	output target_xbar_pkg::data_t                            s_rdata_o,
	output target_xbar_pkg::resp_t                            s_rresp_o,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_arvalid_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_arready_i,
	output target_xbar_pkg::addr_t                            m_araddr_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_rvalid_i,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_rready_o,
	input  target_xbar_pkg::data_t [target_xbar_pkg::NUM_TARGETS-1:0] m_rdata_i,
	input  target_xbar_pkg::resp_t [target_xbar_pkg::NUM_TARGETS-1:0] m_rresp_i,
	output target_xbar_pkg::addr_t                            dec_addr_o,
	input  target_xbar_pkg::tgt_sel_t                         dec_sel_i,
	input  logic                                              dec_hit_i
);
	import target_xbar_pkg::*;

	rd_state_t              state_q;
	tgt_sel_t               sel_q;
	logic [NUM_TARGETS-1:0] sel_onehot;
	addr_t                  ar_addr_q;
	data_t                  rdata_q;
	resp_t                  rresp_q;
	logic                   ar_fire;
	logic                   ar_xfer;
	logic                   r_xfer;

	assign s_arready_o = (state_q == R_IDLE);
	assign ar_fire     = s_arvalid_i && s_arready_o;

	// Decode happens on the capture edge
	assign dec_addr_o = s_araddr_i;

	assign sel_onehot  = NUM_TARGETS'(1) << sel_q;
	assign m_arvalid_o = (state_q == R_ADDR) ? sel_onehot : '0;
	assign m_rready_o  = (state_q == R_DATA) ? sel_onehot : '0;
	assign m_araddr_o  = ar_addr_q;

	assign ar_xfer = (state_q == R_ADDR) && m_arready_i[sel_q];
	assign r_xfer  = (state_q == R_DATA) && m_rvalid_i[sel_q];

	// Returned beat, held until the manager takes it
	assign s_rvalid_o = (state_q == R_RET);
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = rresp_q;

	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			state_q <= R_IDLE;
			sel_q   <= TGT_NIC;
		end else begin
			case (state_q)
				R_IDLE: begin
					if (ar_fire) begin
						sel_q   <= dec_sel_i;
						state_q <= dec_hit_i ? R_ADDR : R_RET;
					end
				end
				R_ADDR: begin
					if (ar_xfer) begin
						state_q <= R_DATA;
					end
				end
				R_DATA: begin
					if (r_xfer) begin
						state_q <= R_RET;
					end
				end
				R_RET: begin
					if (s_rready_i) begin
						state_q <= R_IDLE;
					end
				end
				default: state_q <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge core_clk) begin
		if (ar_fire) begin
			ar_addr_q <= s_araddr_i;
		end
		if (ar_fire && !dec_hit_i) begin
			// Miss returns zero data
			rdata_q <= '0;
			rresp_q <= RESP_DECERR;
		end else if (r_xfer) begin
			rdata_q <= m_rdata_i[sel_q];
			rresp_q <= m_rresp_i[sel_q];
		end
	end

endmodule

// ==== target_xbar/target_write_route.sv ====
`timescale 1ns/1ps

module target_write_route (
	input  logic                                              core_clk,
	input  logic                                              ext_rst,
	input  logic                                              s_awvalid_i,
	output logic                                              s_awready_o,
	input  target_xbar_pkg::addr_t                            s_awaddr_i,
	input  logic                                              s_wvalid_i,
	output logic                                              s_wready_o,
	input  target_xbar_pkg::data_t                            s_wdata_i,
	input  target_xbar_pkg::strb_t                            s_wstrb_i,
	output logic                                              s_bvalid_o,
	input  logic                                              s_bready_i,
	output target_xbar_pkg::resp_t                            s_bresp_o,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_awvalid_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_awready_i,
	output target_xbar_pkg::addr_t                            m_awaddr_o,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_wvalid_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_wready_i,
	output target_xbar_pkg::data_t                            m_wdata_o,
	output target_xbar_pkg::strb_t                            m_wstrb_o,
	input  logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_bvalid_i,
	output logic [target_xbar_pkg::NUM_TARGETS-1:0]           m_bready_o,
	input  target_xbar_pkg::resp_t [target_xbar_pkg::NUM_TARGETS-1:0] m_bresp_i,
	output target_xbar_pkg::addr_t                            dec_addr_o,
	input  target_xbar_pkg::tgt_sel_t                         dec_sel_i,
	input  logic                                              dec_hit_i
);
	import target_xbar_pkg::*;

	wr_state_t              state_q;
	logic                   aw_got_q;
	logic                   w_got_q;
	logic                   aw_pend_q;
	logic                   w_pend_q;
	tgt_sel_t               sel_q;
	logic [NUM_TARGETS-1:0] sel_onehot;
	addr_t                  aw_addr_q;
	data_t                  w_data_q;
	strb_t                  w_strb_q;
	resp_t                  bresp_q;
	logic                   aw_fire;
	logic                   w_fire;
	logic                   both_in;
	logic                   aw_xfer;
	logic                   w_xfer;
	logic                   b_xfer;

	// Manager side, each beat accepted once per transaction
	assign s_awready_o = (state_q == W_IDLE) && !aw_got_q;
	assign s_wready_o  = (state_q == W_IDLE) && !w_got_q;
	assign aw_fire     = s_awvalid_i && s_awready_o;
	assign w_fire      = s_wvalid_i && s_wready_o;
	assign both_in     = (aw_got_q || aw_fire) && (w_got_q || w_fire);

	// Decode the live address when aw and w complete on the same edge
	assign dec_addr_o = aw_got_q ? aw_addr_q : s_awaddr_i;

	// Subordinate side
	assign sel_onehot  = NUM_TARGETS'(1) << sel_q;
	assign m_awvalid_o = aw_pend_q ? sel_onehot : '0;
	assign m_wvalid_o  = w_pend_q ? sel_onehot : '0;
	assign m_bready_o  = (state_q == W_RESP) ? sel_onehot : '0;
	assign m_awaddr_o  = aw_addr_q;
	assign m_wdata_o   = w_data_q;
	assign m_wstrb_o   = w_strb_q;

	assign aw_xfer = aw_pend_q && m_awready_i[sel_q];
	assign w_xfer  = w_pend_q && m_wready_i[sel_q];
	assign b_xfer  = (state_q == W_RESP) && m_bvalid_i[sel_q];

	assign s_bvalid_o = (state_q == W_RET);
	assign s_bresp_o  = bresp_q;

	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			state_q   <= W_IDLE;
			aw_got_q  <= 1'b0;
			w_got_q   <= 1'b0;
			aw_pend_q <= 1'b0;
			w_pend_q  <= 1'b0;
			sel_q     <= TGT_NIC;
		end else begin
			case (state_q)
				W_IDLE: begin
					if (both_in) begin
						aw_got_q <= 1'b0;
						w_got_q  <= 1'b0;
						sel_q    <= dec_sel_i;
						if (dec_hit_i) begin
							aw_pend_q <= 1'b1;
							w_pend_q  <= 1'b1;
							state_q   <= W_ADDR;
						end else begin
							// Unmapped, answer directly
							state_q <= W_RET;
						end
					end else begin
						if (aw_fire) begin
							aw_got_q <= 1'b1;
						end
						if (w_fire) begin
							w_got_q <= 1'b1;
						end
					end
				end
				W_ADDR: begin
					if (aw_xfer) begin
						aw_pend_q <= 1'b0;
					end
					if (w_xfer) begin
						w_pend_q <= 1'b0;
					end
					if ((!aw_pend_q || aw_xfer) && (!w_pend_q || w_xfer)) begin
						state_q <= W_RESP;
					end
				end
				W_RESP: begin
					if (b_xfer) begin
						state_q <= W_RET;
					end
				end
				W_RET: begin
					if (s_bready_i) begin
						state_q <= W_IDLE;
					end
				end
				default: state_q <= W_IDLE;
			endcase
		end
	end

	// Captured beats and held response
	always_ff @(posedge core_clk) begin
		if (aw_fire) begin
			aw_addr_q <= s_awaddr_i;
		end
		if (w_fire) begin
			w_data_q <= s_wdata_i;
			w_strb_q <= s_wstrb_i;
		end
		if ((state_q == W_IDLE) && both_in && !dec_hit_i) begin
			bresp_q <= RESP_DECERR;
		end else if (b_xfer) begin
			bresp_q <= m_bresp_i[sel_q];
		end
	end

endmodule

// ==== target_xbar/target_addr_decode.sv ====
`timescale 1ns/1ps

module target_addr_decode (
	input  target_xbar_pkg::addr_t    addr_i,
	output target_xbar_pkg::tgt_sel_t sel_o,
	output logic                      hit_o
);
	import target_xbar_pkg::*;

	logic nic_hit;
	logic can_hit;
	logic uart_hit;

	// Window match ignores the offset bits inside the window
	assign nic_hit  = (addr_i & ~NIC_MASK) == NIC_BASE;
	assign can_hit  = (addr_i & ~CAN_MASK) == CAN_BASE;
	assign uart_hit = (addr_i & ~UART_MASK) == UART_BASE;

	// Windows do not overlap, so the order here is arbitrary
	always_comb begin
		sel_o = TGT_NIC;
		if (can_hit) begin
			sel_o = TGT_CAN;
		end
		if (uart_hit) begin
			sel_o = TGT_UART;
		end
	end

	assign hit_o = nic_hit | can_hit | uart_hit;

endmodule

// ==== common/target_xbar_pkg.sv ====
package target_xbar_pkg;

	// Bus geometry
	localparam int ADDR_W      = 32;
	localparam int DATA_W      = 32;
	localparam int STRB_W      = 4;
	localparam int NUM_TARGETS = 3;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [1:0]        resp_t;
	typedef logic [1:0]        tgt_sel_t;

	// Subordinate indices
	localparam tgt_sel_t TGT_NIC  = 2'd0;
	localparam tgt_sel_t TGT_CAN  = 2'd1;
	localparam tgt_sel_t TGT_UART = 2'd2;

	// Network controller registers, 128 KiB
	localparam addr_t NIC_BASE  = 32'h0000_0000;
	localparam addr_t NIC_MASK  = 32'h0001_ffff;

	// CAN controller pair, 4 KiB
	localparam addr_t CAN_BASE  = 32'h0002_0000;
	localparam addr_t CAN_MASK  = 32'h0000_0fff;

	// Quad UART, 4 KiB
	localparam addr_t UART_BASE = 32'h0002_1000;
	localparam addr_t UART_MASK = 32'h0000_0fff;

	// AXI response codes
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	// Write routing FSM
	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR,
		W_RESP,
		W_RET
	} wr_state_t;

	// Read routing FSM
	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA,
		R_RET
	} rd_state_t;

endpackage
